// ==== design/csr_pkg.sv ====
// CSR block shared definitions
// Register map, write and exception codes, bundles and update helpers

`default_nettype none

package csr_pkg;

	localparam int XLEN = 32; // RV32 only

	typedef logic [11:0] csr_addr_t;
	typedef logic [1:0]  csr_wtype_t;
	typedef logic [3:0]  except_t;

	// ------------------------------
	// Register map
	localparam csr_addr_t CSR_MVENDORID     = 12'hf11; // Read-only ID block
	localparam csr_addr_t CSR_MARCHID       = 12'hf12;
	localparam csr_addr_t CSR_MIMPID        = 12'hf13;
	localparam csr_addr_t CSR_MHARTID       = 12'hf14;
	localparam csr_addr_t CSR_MSTATUS       = 12'h300; // Trap setup
	localparam csr_addr_t CSR_MISA          = 12'h301;
	localparam csr_addr_t CSR_MIE           = 12'h304;
	localparam csr_addr_t CSR_MTVEC         = 12'h305;
	localparam csr_addr_t CSR_MSTATUSH      = 12'h310;
	localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
	localparam csr_addr_t CSR_MSCRATCH      = 12'h340; // Trap handling
	localparam csr_addr_t CSR_MEPC          = 12'h341;
	localparam csr_addr_t CSR_MCAUSE        = 12'h342;
	localparam csr_addr_t CSR_MTVAL         = 12'h343;
	localparam csr_addr_t CSR_MIP           = 12'h344;
	localparam csr_addr_t CSR_MCYCLE        = 12'hb00; // Counters
	localparam csr_addr_t CSR_MINSTRET      = 12'hb02;
	localparam csr_addr_t CSR_MCYCLEH       = 12'hb80;
	localparam csr_addr_t CSR_MINSTRETH     = 12'hb82;
	localparam csr_addr_t CSR_MEIE0         = 12'hbe0; // Custom external IRQ regs
	localparam csr_addr_t CSR_MEIP0         = 12'hfe0;
	localparam csr_addr_t CSR_MLEI          = 12'hfe4;

	// ------------------------------
	// Codes
	localparam csr_wtype_t WTYPE_W = 2'h0; // Plain write
	localparam csr_wtype_t WTYPE_S = 2'h1; // Set bits
	localparam csr_wtype_t WTYPE_C = 2'h2; // Clear bits

	localparam except_t EXCEPT_NONE = 4'hf;
	localparam except_t EXCEPT_MRET = 4'ha; // Not a cause, pops the enable stack

	// Masks and reset values
	localparam logic [XLEN-1:0] MIE_WMASK     = 32'h0000_0888; // meie, mtie, msie
	localparam logic [XLEN-1:0] MTVEC_WMASK   = 32'hffff_fffd; // Mode bit 1 reserved
	localparam logic [XLEN-1:0] MEPC_MASK     = 32'hffff_fffe; // Halfword aligned
	localparam logic [XLEN-1:0] MTVEC_INIT    = 32'h0000_0000;
	localparam logic [XLEN-1:0] MVENDORID_VAL = 32'h0000_0000;
	localparam logic [XLEN-1:0] MARCHID_VAL   = 32'h0000_0001;
	localparam logic [XLEN-1:0] MIMPID_VAL    = 32'h0000_0100;
	localparam logic [XLEN-1:0] MHARTID_VAL   = 32'h0000_0000;

	// ------------------------------
	// Bundles
	typedef struct packed {
		logic            wen;
		csr_addr_t       addr;
		csr_wtype_t      wtype;
		logic [XLEN-1:0] wdata;
	} csr_wr_t;

	typedef struct packed {
		logic            mstatus_mie;
		logic            mstatus_mpie;
		logic [XLEN-1:0] mie;
		logic [XLEN-1:0] mtvec_base;   // Low two bits always zero
		logic            mtvec_vec;    // Vectored interrupts
		logic [XLEN-1:0] mepc;
		logic            mcause_irq;
		logic [4:0]      mcause_code;
	} trap_state_t;

	typedef struct packed {
		logic       take;       // Entry accepted this cycle
		logic       is_mret;
		logic       cause_irq;
		logic [5:0] cause_code;
	} trap_take_t;

	// Write to a register through its write type, under a mask of live bits
	function automatic logic [XLEN-1:0] csr_update(
		input logic [XLEN-1:0] prev,
		input csr_wr_t         wr,
		input logic [XLEN-1:0] mask
	);
		logic [XLEN-1:0] next;
		case (wr.wtype)
			WTYPE_S: next = prev | wr.wdata;
			WTYPE_C: next = prev & ~wr.wdata;
			default: next = wr.wdata;
		endcase
		return (next & mask) | (prev & ~mask);
	endfunction

	function automatic logic csr_hit(input csr_wr_t wr, input csr_addr_t a);
		return wr.wen && (wr.addr == a);
	endfunction

	// Index of lowest set bit, 0 when nothing is set
	function automatic logic [4:0] prio_encode(input logic [31:0] req);
		logic [4:0] idx;
		idx = '0;
		for (int i = 31; i >= 0; i--) begin
			if (req[i])
				idx = 5'(i);
		end
		return idx;
	endfunction

endpackage

`default_nettype wire

// ==== design/csr_trap_regs.sv ====
// Trap setup and handling registers
// Enable stack, mscratch, mtvec, mepc, mcause and mie with trap/mret updates

`default_nettype none
`timescale 1ns/1ns

module csr_trap_regs (
	input  logic                     clk,
	input  logic                     rst_n,
	input  csr_pkg::csr_wr_t         wr,
	input  csr_pkg::trap_take_t      take,
	input  logic [csr_pkg::XLEN-1:0] mepc_in,
	output csr_pkg::trap_state_t     state,
	output logic [csr_pkg::XLEN-1:0] mscratch
);
	import csr_pkg::*;

	logic            mstatus_mie;  // Global enable
	logic            mstatus_mpie; // Stacked enable
	logic [XLEN-1:0] mie_q;
	logic [XLEN-1:2] mtvec_base;
	logic            mtvec_vec;
	logic [XLEN-1:0] mepc_q;
	logic            mcause_irq;
	logic [4:0]      mcause_code;

	logic            trap_entry; // Real trap, not mret
	logic [XLEN-1:0] mstatus_wr;
	logic [XLEN-1:0] mtvec_wr;
	logic [XLEN-1:0] mcause_wr;

	assign trap_entry = take.take && !take.is_mret;
	// Register images under their write masks
	assign mstatus_wr = csr_update({24'h0, mstatus_mpie, 3'h0, mstatus_mie, 3'h0}, wr, 32'h88);
	assign mtvec_wr   = csr_update({mtvec_base, 1'b0, mtvec_vec}, wr, MTVEC_WMASK);
	assign mcause_wr  = csr_update({mcause_irq, 26'h0, mcause_code}, wr, 32'h8000_001f);

	// ------------------------------
	// Enable stack
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end else if (take.take) begin
			if (take.is_mret) begin // Pop, MPIE back to 1
				mstatus_mie  <= mstatus_mpie;
				mstatus_mpie <= 1'b1;
			end else begin // Push and mask
				mstatus_mpie <= mstatus_mie;
				mstatus_mie  <= 1'b0;
			end
		end else if (csr_hit(wr, CSR_MSTATUS)) begin
			mstatus_mie  <= mstatus_wr[3];
			mstatus_mpie <= mstatus_wr[7];
		end
	end

	// Trap entry beats a same-cycle write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mepc_q      <= '0;
			mcause_irq  <= 1'b0;
			mcause_code <= '0;
		end else if (trap_entry) begin
			mepc_q      <= mepc_in & MEPC_MASK;
			mcause_irq  <= take.cause_irq;
			mcause_code <= take.cause_code[4:0]; // Codes above 31 wrap, as on read
		end else begin
			if (csr_hit(wr, CSR_MEPC))
				mepc_q <= csr_update(mepc_q, wr, MEPC_MASK);
			if (csr_hit(wr, CSR_MCAUSE)) begin
				mcause_irq  <= mcause_wr[31];
				mcause_code <= mcause_wr[4:0];
			end
		end
	end

	// ------------------------------
	// Software-only registers
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mscratch   <= '0;
			mie_q      <= '0;
			mtvec_base <= MTVEC_INIT[XLEN-1:2];
			mtvec_vec  <= MTVEC_INIT[0];
		end else begin
			if (csr_hit(wr, CSR_MSCRATCH))
				mscratch <= csr_update(mscratch, wr, '1);
			if (csr_hit(wr, CSR_MIE))
				mie_q <= csr_update(mie_q, wr, MIE_WMASK);
			if (csr_hit(wr, CSR_MTVEC)) begin
				mtvec_base <= mtvec_wr[XLEN-1:2];
				mtvec_vec  <= mtvec_wr[0];
			end
		end
	end

	assign state = '{
		mstatus_mie:  mstatus_mie,
		mstatus_mpie: mstatus_mpie,
		mie:          mie_q,
		mtvec_base:   {mtvec_base, 2'b00},
		mtvec_vec:    mtvec_vec,
		mepc:         mepc_q,
		mcause_irq:   mcause_irq,
		mcause_code:  mcause_code
	};

endmodule

`default_nettype wire

// ==== design/csr_counters.sv ====
// Cycle and retired-instruction counters
// Free-running unless inhibited, both halves writable

`default_nettype none
`timescale 1ns/1ns

module csr_counters #(
	parameter int W_COUNTER = 64 // Bits above this hold their value
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  csr_pkg::csr_wr_t         wr,
	input  logic                     instr_ret,
	output logic [csr_pkg::XLEN-1:0] mcycle,
	output logic [csr_pkg::XLEN-1:0] mcycleh,
	output logic [csr_pkg::XLEN-1:0] minstret,
	output logic [csr_pkg::XLEN-1:0] minstreth,
	output logic                     inhibit_cy,
	output logic                     inhibit_ir
);
	import csr_pkg::*;

	localparam logic [2*XLEN-1:0] HOLD_MASK = {(2*XLEN){1'b1}} << W_COUNTER; // Frozen bits

	logic [1:0]      ctr_inc;      // 0 cycle, 1 instret
	logic [XLEN-1:0] inhibit_next;

	assign ctr_inc[0] = !inhibit_cy;
	assign ctr_inc[1] = !inhibit_ir && instr_ret;

	// ------------------------------
	// One 64-bit counter per event
	for (genvar i = 0; i < 2; i++) begin : g_ctr
		localparam csr_addr_t LO_ADDR = (i == 0) ? CSR_MCYCLE  : CSR_MINSTRET;
		localparam csr_addr_t HI_ADDR = (i == 0) ? CSR_MCYCLEH : CSR_MINSTRETH;

		logic [2*XLEN-1:0] ctr_q;
		logic [2*XLEN-1:0] ctr_next;

		assign ctr_next = ((ctr_q + 1'b1) & ~HOLD_MASK) | (ctr_q & HOLD_MASK);

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				ctr_q <= '0;
			end else begin
				if (ctr_inc[i])
					ctr_q <= ctr_next;
				if (csr_hit(wr, LO_ADDR)) // Later assignment, so write wins
					ctr_q[XLEN-1:0] <= csr_update(ctr_q[XLEN-1:0], wr, '1);
				if (csr_hit(wr, HI_ADDR))
					ctr_q[2*XLEN-1:XLEN] <= csr_update(ctr_q[2*XLEN-1:XLEN], wr, '1);
			end
		end
	end

	assign mcycle    = g_ctr[0].ctr_q[XLEN-1:0];
	assign mcycleh   = g_ctr[0].ctr_q[2*XLEN-1:XLEN];
	assign minstret  = g_ctr[1].ctr_q[XLEN-1:0];
	assign minstreth = g_ctr[1].ctr_q[2*XLEN-1:XLEN];

	// Inhibit bits sit at CY (0) and IR (2)
	assign inhibit_next = csr_update({29'h0, inhibit_ir, 1'b0, inhibit_cy}, wr, 32'h5);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			inhibit_cy <= 1'b0;
			inhibit_ir <= 1'b0;
		end else if (csr_hit(wr, CSR_MCOUNTINHIBIT)) begin
			inhibit_cy <= inhibit_next[0];
			inhibit_ir <= inhibit_next[2];
		end
	end

endmodule

`default_nettype wire

// ==== design/csr_irq_ctrl.sv ====
// Interrupt control and trap request generation
// Registers IRQ lines, holds meie0, picks the cause and the trap target

`default_nettype none
`timescale 1ns/1ns

module csr_irq_ctrl #(
	parameter int NUM_IRQ = 16 // External lines, up to 32
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  csr_pkg::csr_wr_t         wr,
	input  csr_pkg::except_t         except,
	input  logic [NUM_IRQ-1:0]       irq,
	input  logic                     irq_software,
	input  logic                     irq_timer,
	input  csr_pkg::trap_state_t     state,
	input  logic                     trap_enter_rdy,
	output logic [csr_pkg::XLEN-1:0] trap_addr,
	output logic                     trap_is_irq,
	output logic                     trap_enter_vld,
	output csr_pkg::trap_take_t      take,
	output logic [csr_pkg::XLEN-1:0] mip,
	output logic [csr_pkg::XLEN-1:0] meie0,
	output logic [csr_pkg::XLEN-1:0] meip0,
	output logic [csr_pkg::XLEN-1:0] mlei
);
	import csr_pkg::*;

	localparam logic [XLEN-1:0] MEIE0_WMASK = ~({XLEN{1'b1}} << NUM_IRQ); // Implemented lines
	localparam logic [XLEN-1:0] MEIP_BIT    = 32'h0000_0800;

	logic [NUM_IRQ-1:0] irq_q;
	logic               sw_q;
	logic               tm_q;
	logic [XLEN-1:0]    std_req;     // Enabled standard sources, meip excluded
	logic               ext_pending;
	logic               std_active;
	logic               ext_active;
	logic               exc_req;     // Exception or mret present
	logic [4:0]         std_num;
	logic [4:0]         ext_num;
	logic [5:0]         irq_cause;
	logic [5:0]         vector_sel;

	// ------------------------------
	// Input registers and meie0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			irq_q <= '0;
			sw_q  <= 1'b0;
			tm_q  <= 1'b0;
			meie0 <= '0;
		end else begin
			irq_q <= irq;
			sw_q  <= irq_software;
			tm_q  <= irq_timer;
			if (csr_hit(wr, CSR_MEIE0))
				meie0 <= csr_update(meie0, wr, MEIE0_WMASK);
		end
	end

	assign meip0       = XLEN'(irq_q);
	assign ext_pending = |(meie0 & meip0);
	assign mip         = {20'h0, ext_pending, 3'h0, tm_q, 3'h0, sw_q, 3'h0};

	// External lines trap through their own codes, not through mip.meip
	assign std_req    = mip & ~MEIP_BIT & state.mie;
	assign std_active = |std_req && state.mstatus_mie;
	assign ext_active = ext_pending && state.mie[11] && state.mstatus_mie;
	assign std_num    = prio_encode(std_req);
	assign ext_num    = prio_encode(meie0 & meip0); // Lowest enabled pending line
	assign mlei       = XLEN'(ext_num);

	assign irq_cause = std_active ? {1'b0, std_num} :
		ext_active ? 6'd16 + {1'b0, ext_num} : 6'd0;

	// ------------------------------
	// Trap request
	assign exc_req        = except != EXCEPT_NONE; // Exceptions beat interrupts
	assign trap_enter_vld = exc_req || std_active || ext_active;
	assign trap_is_irq    = !exc_req;
	assign vector_sel     = (!exc_req && state.mtvec_vec) ? irq_cause : 6'd0;

	assign trap_addr = (except == EXCEPT_MRET) ? state.mepc :
		state.mtvec_base + {24'h0, vector_sel, 2'b00};

	assign take = '{
		take:       trap_enter_vld && trap_enter_rdy,
		is_mret:    except == EXCEPT_MRET,
		cause_irq:  !exc_req,
		cause_code: exc_req ? {2'b00, except} : irq_cause
	};

endmodule

`default_nettype wire

// ==== design/csr_read_decode.sv ====
// CSR read mux and access check
// Combinational read data and illegal flag for the register port

`default_nettype none
`timescale 1ns/1ns

module csr_read_decode (
	input  csr_pkg::csr_addr_t       addr,
	input  logic                     wen,
	input  logic                     ren,
	input  csr_pkg::trap_state_t     state,
	input  logic [csr_pkg::XLEN-1:0] mscratch,
	input  logic [csr_pkg::XLEN-1:0] mcycle,
	input  logic [csr_pkg::XLEN-1:0] mcycleh,
	input  logic [csr_pkg::XLEN-1:0] minstret,
	input  logic [csr_pkg::XLEN-1:0] minstreth,
	input  logic                     inhibit_cy,
	input  logic                     inhibit_ir,
	input  logic [csr_pkg::XLEN-1:0] mip,
	input  logic [csr_pkg::XLEN-1:0] meie0,
	input  logic [csr_pkg::XLEN-1:0] meip0,
	input  logic [csr_pkg::XLEN-1:0] mlei,
	output logic [csr_pkg::XLEN-1:0] rdata,
	output logic                     illegal
);
	import csr_pkg::*;

	localparam logic [XLEN-1:0] MISA_VAL = 32'h4000_0100; // MXL 32-bit, I only

	logic decode_match;
	logic read_only;

	always_comb begin
		decode_match = 1'b1; // Dropped by default branch only
		rdata        = '0;
		case (addr)
			CSR_MSTATUS:       rdata = {19'h0, 2'b11, 3'h0, state.mstatus_mpie, // MPP is M
				3'h0, state.mstatus_mie, 3'h0};
			CSR_MSTATUSH,
			CSR_MTVAL:         rdata = '0; // Tied off
			CSR_MISA:          rdata = MISA_VAL;
			CSR_MVENDORID:     rdata = MVENDORID_VAL;
			CSR_MARCHID:       rdata = MARCHID_VAL;
			CSR_MIMPID:        rdata = MIMPID_VAL;
			CSR_MHARTID:       rdata = MHARTID_VAL;
			CSR_MSCRATCH:      rdata = mscratch;
			CSR_MEPC:          rdata = state.mepc;
			CSR_MCAUSE:        rdata = {state.mcause_irq, 26'h0, state.mcause_code}; // Sign = irq
			CSR_MIE:           rdata = state.mie;
			CSR_MIP:           rdata = mip; // Writes accepted, ignored
			CSR_MTVEC:         rdata = {state.mtvec_base[XLEN-1:2], 1'b0, state.mtvec_vec};
			CSR_MCOUNTINHIBIT: rdata = {29'h0, inhibit_ir, 1'b0, inhibit_cy};
			CSR_MCYCLE:        rdata = mcycle;
			CSR_MCYCLEH:       rdata = mcycleh;
			CSR_MINSTRET:      rdata = minstret;
			CSR_MINSTRETH:     rdata = minstreth;
			CSR_MEIE0:         rdata = meie0;
			CSR_MEIP0:         rdata = meip0;
			CSR_MLEI:          rdata = mlei;
			default:           decode_match = 1'b0;
		endcase
	end

	// IDs and external status are read-only
	assign read_only = addr inside {CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
		CSR_MEIP0, CSR_MLEI};

	assign illegal = (wen || ren) && (!decode_match || (wen && read_only));

endmodule

`default_nettype wire

// ==== design/csr_file.sv ====
// Machine-mode CSR block for a small RV32 core
// Register port, trap registers, counters and interrupt/trap request logic

`default_nettype none
`timescale 1ns/1ns

module csr_file #(
	parameter int NUM_IRQ   = 16, // External lines, up to 32
	parameter int W_COUNTER = 64  // Live counter bits, 33 to 64
) (
	input  logic                     clk,
	input  logic                     rst_n,
	// Register port
	input  csr_pkg::csr_addr_t       addr,
	input  logic [csr_pkg::XLEN-1:0] wdata,
	input  csr_pkg::csr_wtype_t      wtype,
	input  logic                     wen,
	input  logic                     ren,
	output logic [csr_pkg::XLEN-1:0] rdata,
	output logic                     illegal,
	// Trap handshake
	output logic [csr_pkg::XLEN-1:0] trap_addr,
	output logic                     trap_is_irq,
	output logic                     trap_enter_vld,
	input  logic                     trap_enter_rdy,
	input  logic [csr_pkg::XLEN-1:0] mepc_in,
	// Events from the core
	input  csr_pkg::except_t         except,
	input  logic [NUM_IRQ-1:0]       irq,
	input  logic                     irq_software,
	input  logic                     irq_timer,
	input  logic                     instr_ret
);
	import csr_pkg::*;

	csr_wr_t         wr;    // Write request bundle
	trap_state_t     state; // Trap registers seen by irq ctrl and read mux
	trap_take_t      take;  // Accepted trap or mret
	logic [XLEN-1:0] mscratch;
	logic [XLEN-1:0] mcycle, mcycleh, minstret, minstreth;
	logic            inhibit_cy, inhibit_ir;
	logic [XLEN-1:0] mip, meie0, meip0, mlei;

	assign wr = '{wen: wen, addr: addr, wtype: wtype, wdata: wdata};

	csr_trap_regs trap_regs_i (
		.clk, .rst_n, .wr, .take, .mepc_in, .state, .mscratch
	);

	csr_counters #(.W_COUNTER(W_COUNTER)) counters_i (
		.clk, .rst_n, .wr, .instr_ret,
		.mcycle, .mcycleh, .minstret, .minstreth, .inhibit_cy, .inhibit_ir
	);

	csr_irq_ctrl #(.NUM_IRQ(NUM_IRQ)) irq_ctrl_i (
		.clk, .rst_n, .wr, .except, .irq, .irq_software, .irq_timer, .state,
		.trap_enter_rdy, .trap_addr, .trap_is_irq, .trap_enter_vld, .take,
		.mip, .meie0, .meip0, .mlei
	);

	csr_read_decode read_decode_i (
		.addr, .wen, .ren, .state, .mscratch,
		.mcycle, .mcycleh, .minstret, .minstreth, .inhibit_cy, .inhibit_ir,
		.mip, .meie0, .meip0, .mlei, .rdata, .illegal
	);

endmodule

`default_nettype wire

// ==== dv/csr_tb.sv ====
// Self-checking testbench for the machine-mode CSR block
// Random register traffic, counters, exceptions and interrupts against a model

`default_nettype none
`timescale 1ns/1ns

module csr_tb;
	import csr_pkg::*;

	localparam int NUM_IRQ     = 16;
	localparam int N_REG       = 60; // Random register writes
	localparam int N_ILL       = 40; // Random unmapped accesses
	localparam int N_EXC       = 10; // Exception plus mret rounds
	localparam int N_IRQ_IT    = 30; // Interrupt rounds
	localparam int TEST_CYCLES = 10 + 7*N_REG + N_ILL + 12 + 40 + 10*N_EXC + 8*N_IRQ_IT;
	localparam int TIMEOUT_NS  = 8 * (TEST_CYCLES + 100);
	localparam logic [31:0] MEIE0_MASK = 32'((64'd1 << NUM_IRQ) - 1); // Implemented lines

	logic            clk;
	logic            rst_n;
	csr_addr_t       addr;
	logic [XLEN-1:0] wdata;
	csr_wtype_t      wtype;
	logic            wen;
	logic            ren;
	logic [XLEN-1:0] rdata;
	logic            illegal;
	logic [XLEN-1:0] trap_addr;
	logic            trap_is_irq;
	logic            trap_enter_vld;
	logic            trap_enter_rdy;
	logic [XLEN-1:0] mepc_in;
	except_t         except;
	logic [NUM_IRQ-1:0] irq;
	logic            irq_software;
	logic            irq_timer;
	logic            instr_ret;

	// Reference model state
	logic [31:0] m_mscratch, m_mie, m_mtvec, m_mepc, m_meie0, m_mcause;
	logic        m_gie;  // mstatus.MIE
	logic        m_mpie;
	integer      seed = 32'h801098b9;

	// Scratch for the main sequence
	logic [31:0] v0, rnd, pc, std_req, en_pend, cause, exp_addr;
	logic [31:0] r_irq;
	csr_addr_t   ra;
	csr_wtype_t  wt;
	except_t     code;
	logic        r_sw, r_tm, std_act, ext_act, exp_vld;
	int          cnt;

	csr_file #(.NUM_IRQ(NUM_IRQ), .W_COUNTER(64)) dut_i (
		.clk, .rst_n, .addr, .wdata, .wtype, .wen, .ren, .rdata, .illegal,
		.trap_addr, .trap_is_irq, .trap_enter_vld, .trap_enter_rdy, .mepc_in,
		.except, .irq, .irq_software, .irq_timer, .instr_ret
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// ------------------------------
	// Helpers
	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
			$display("TEST FAIL");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	function automatic logic [31:0] apply_wr(input logic [31:0] prev, input csr_wtype_t t,
		input logic [31:0] d, input logic [31:0] mask);
		logic [31:0] n;
		case (t)
			WTYPE_S: n = prev | d;
			WTYPE_C: n = prev & ~d;
			default: n = d;
		endcase
		return (n & mask) | (prev & ~mask); // Dead bits keep old value
	endfunction

	function automatic logic [31:0] lowest_bit(input logic [31:0] v);
		logic [31:0] idx;
		idx = 0;
		for (int i = 31; i >= 0; i--)
			if (v[i])
				idx = i;
		return idx;
	endfunction

	function automatic logic is_mapped(input csr_addr_t a);
		case (a)
			CSR_MSTATUS, CSR_MSTATUSH, CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
			CSR_MHARTID, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIE, CSR_MIP,
			CSR_MTVEC, CSR_MCYCLE, CSR_MINSTRET, CSR_MCYCLEH, CSR_MINSTRETH,
			CSR_MCOUNTINHIBIT, CSR_MEIE0, CSR_MEIP0, CSR_MLEI: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] mstatus_word();
		return 32'h1800 | (32'(m_mpie) << 7) | (32'(m_gie) << 3); // MPP reads as M
	endfunction

	task automatic csr_write(input csr_addr_t a, input csr_wtype_t t, input logic [31:0] d,
		input logic exp_ill);
		@(posedge clk);
		addr  <= a;
		wtype <= t;
		wdata <= d;
		wen   <= 1'b1; // Commits on the next edge
		ren   <= 1'b0;
		@(negedge clk);
		expect_eq("illegal", illegal, exp_ill);
	endtask

	task automatic csr_read(input csr_addr_t a, output logic [31:0] v);
		@(posedge clk);
		addr <= a;
		wen  <= 1'b0;
		ren  <= 1'b1;
		@(negedge clk);
		v = rdata;
	endtask

	task automatic read_expect(input csr_addr_t a, input logic [31:0] exp, input string name);
		logic [31:0] v;
		csr_read(a, v);
		expect_eq("illegal", illegal, 1'b0);
		expect_eq(name, v, exp);
	endtask

	// Write a modelled register and track it
	task automatic write_tracked(input csr_addr_t a, input csr_wtype_t t, input logic [31:0] d);
		logic [31:0] mst;
		csr_write(a, t, d, 1'b0);
		case (a)
			CSR_MSCRATCH: m_mscratch = apply_wr(m_mscratch, t, d, 32'hffff_ffff);
			CSR_MIE:      m_mie      = apply_wr(m_mie, t, d, 32'h0000_0888);
			CSR_MTVEC:    m_mtvec    = apply_wr(m_mtvec, t, d, 32'hffff_fffd);
			CSR_MEPC:     m_mepc     = apply_wr(m_mepc, t, d, 32'hffff_fffe);
			CSR_MEIE0:    m_meie0    = apply_wr(m_meie0, t, d, MEIE0_MASK);
			CSR_MSTATUS: begin
				mst    = apply_wr(mstatus_word(), t, d, 32'h88);
				m_gie  = mst[3];
				m_mpie = mst[7];
			end
			default: ;
		endcase
	endtask

	task automatic verify_model();
		read_expect(CSR_MSCRATCH, m_mscratch, "mscratch");
		read_expect(CSR_MIE, m_mie, "mie");
		read_expect(CSR_MTVEC, m_mtvec, "mtvec");
		read_expect(CSR_MEPC, m_mepc, "mepc");
		read_expect(CSR_MEIE0, m_meie0, "meie0");
		read_expect(CSR_MSTATUS, mstatus_word(), "mstatus");
	endtask

	task automatic drive_events(input except_t e, input logic rdy, input logic [31:0] epc);
		@(posedge clk);
		except         <= e;
		trap_enter_rdy <= rdy;
		mepc_in        <= epc;
		wen            <= 1'b0;
		@(negedge clk);
	endtask

	initial begin
		#(TIMEOUT_NS);
		$display("TEST FAIL");
		$fatal(1, "Timeout: tests did not finish within %0d ns", TIMEOUT_NS);
	end

	// ------------------------------
	// Main sequence
	initial begin
		rst_n = 1'b0;
		addr = '0;
		wdata = '0;
		wtype = WTYPE_W;
		wen = 1'b0;
		ren = 1'b0;
		trap_enter_rdy = 1'b0;
		mepc_in = '0;
		except = EXCEPT_NONE;
		irq = '0;
		irq_software = 1'b0;
		irq_timer = 1'b0;
		instr_ret = 1'b0;
		{m_mscratch, m_mie, m_mepc, m_meie0, m_mcause} = '0;
		m_mtvec = 32'h0; // mtvec reset value
		m_gie = 1'b0;
		m_mpie = 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		expect_eq("trap_enter_vld", trap_enter_vld, 1'b0);
		expect_eq("illegal", illegal, 1'b0);
		verify_model();

		// Register access with all write types
		for (int n = 0; n < N_REG; n++) begin
			rnd = $unsigned($random(seed)) % 5;
			ra  = (rnd == 0) ? CSR_MSCRATCH : (rnd == 1) ? CSR_MIE : (rnd == 2) ? CSR_MTVEC :
				(rnd == 3) ? CSR_MEPC : CSR_MEIE0;
			wt  = csr_wtype_t'($unsigned($random(seed)) % 3);
			write_tracked(ra, wt, $random(seed));
			verify_model();
		end

		// Illegal accesses change nothing
		for (int n = 0; n < N_ILL; n++) begin
			ra = csr_addr_t'($random(seed));
			if (!is_mapped(ra)) begin
				if (n % 2)
					csr_write(ra, WTYPE_W, $random(seed), 1'b1);
				else begin
					csr_read(ra, v0);
					expect_eq("illegal", illegal, 1'b1);
				end
			end
		end
		csr_write(CSR_MVENDORID, WTYPE_W, $random(seed), 1'b1);
		csr_write(CSR_MARCHID, WTYPE_S, $random(seed), 1'b1);
		csr_write(CSR_MIMPID, WTYPE_C, $random(seed), 1'b1);
		csr_write(CSR_MHARTID, WTYPE_W, $random(seed), 1'b1);
		csr_write(CSR_MEIP0, WTYPE_W, $random(seed), 1'b1);
		csr_write(CSR_MLEI, WTYPE_S, $random(seed), 1'b1);
		verify_model();

		// Counters
		csr_read(CSR_MCYCLE, v0);
		@(negedge clk);
		expect_eq("mcycle", rdata, v0 + 1);
		csr_write(CSR_MCOUNTINHIBIT, WTYPE_S, 32'h1, 1'b0); // Freeze mcycle
		csr_read(CSR_MCYCLE, v0);
		@(negedge clk);
		expect_eq("mcycle", rdata, v0);
		read_expect(CSR_MCOUNTINHIBIT, 32'h1, "mcountinhibit");
		csr_write(CSR_MCOUNTINHIBIT, WTYPE_C, 32'h1, 1'b0);
		csr_read(CSR_MINSTRET, v0);
		cnt = 0;
		for (int n = 0; n < 24; n++) begin
			rnd = $random(seed);
			@(posedge clk);
			instr_ret <= rnd[0];
			cnt += rnd[0];
		end
		@(posedge clk);
		instr_ret <= 1'b0;
		@(negedge clk);
		expect_eq("minstret", rdata, v0 + cnt);
		rnd = $random(seed);
		csr_write(CSR_MCYCLEH, WTYPE_W, rnd, 1'b0);
		read_expect(CSR_MCYCLEH, rnd, "mcycleh");

		// Exception entry, then mret
		for (int n = 0; n < N_EXC; n++) begin
			write_tracked(CSR_MSTATUS, WTYPE_W, $random(seed));
			code = except_t'($unsigned($random(seed)) % 15);
			if (code == EXCEPT_MRET)
				code = 4'd2;
			pc = $random(seed);
			drive_events(code, 1'b0, pc); // Held off by ready
			expect_eq("trap_enter_vld", trap_enter_vld, 1'b1);
			drive_events(code, 1'b1, pc);
			expect_eq("trap_addr", trap_addr, m_mtvec & ~32'h3);
			expect_eq("trap_is_irq", trap_is_irq, 1'b0);
			drive_events(EXCEPT_NONE, 1'b0, 32'h0); // Entry on this edge
			m_mepc   = pc & ~32'h1;
			m_mcause = 32'(code);
			m_mpie   = m_gie;
			m_gie    = 1'b0;
			read_expect(CSR_MEPC, m_mepc, "mepc");
			read_expect(CSR_MCAUSE, m_mcause, "mcause");
			read_expect(CSR_MSTATUS, mstatus_word(), "mstatus");
			drive_events(EXCEPT_MRET, 1'b1, 32'h0);
			expect_eq("trap_enter_vld", trap_enter_vld, 1'b1);
			expect_eq("trap_addr", trap_addr, m_mepc);
			drive_events(EXCEPT_NONE, 1'b0, 32'h0);
			m_gie  = m_mpie; // Pop
			m_mpie = 1'b1;
			read_expect(CSR_MSTATUS, mstatus_word(), "mstatus");
		end

		// Interrupts, ready held low throughout
		for (int n = 0; n < N_IRQ_IT; n++) begin
			write_tracked(CSR_MEIE0, WTYPE_W, $random(seed));
			write_tracked(CSR_MIE, WTYPE_W, $random(seed));
			write_tracked(CSR_MSTATUS, WTYPE_W, $random(seed));
			write_tracked(CSR_MTVEC, WTYPE_W, $random(seed));
			r_irq = $random(seed) & $random(seed) & MEIE0_MASK; // Sparse lines
			rnd   = $random(seed);
			r_sw  = rnd[0];
			r_tm  = rnd[1];
			@(posedge clk);
			irq          <= r_irq[NUM_IRQ-1:0];
			irq_software <= r_sw;
			irq_timer    <= r_tm;
			addr         <= CSR_MLEI;
			wen          <= 1'b0;
			ren          <= 1'b1;
			@(posedge clk); // Inputs registered here
			@(negedge clk);
			en_pend  = m_meie0 & r_irq;
			std_req  = ((32'(r_tm) << 7) | (32'(r_sw) << 3)) & m_mie;
			std_act  = (|std_req) && m_gie;
			ext_act  = (|en_pend) && m_mie[11] && m_gie;
			exp_vld  = std_act || ext_act;
			cause    = std_act ? lowest_bit(std_req) : 32'd16 + lowest_bit(en_pend);
			exp_addr = (m_mtvec & ~32'h3) + (m_mtvec[0] ? 4 * cause : 32'h0);
			expect_eq("trap_enter_vld", trap_enter_vld, exp_vld);
			expect_eq("mlei", rdata, lowest_bit(en_pend));
			if (exp_vld) begin
				expect_eq("trap_is_irq", trap_is_irq, 1'b1);
				expect_eq("trap_addr", trap_addr, exp_addr);
			end
			@(posedge clk);
			irq          <= '0;
			irq_software <= 1'b0;
			irq_timer    <= 1'b0;
			read_expect(CSR_MCAUSE, m_mcause, "mcause"); // No entry without ready
		end

		$display("TEST PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
design/csr_pkg.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_irq_ctrl.sv
design/csr_read_decode.sv
design/csr_file.sv
dv/csr_tb.sv

// ==== Bender.yml ====
package:
  name: csr_file

sources:
  - design/csr_pkg.sv
  - design/csr_trap_regs.sv
  - design/csr_counters.sv
  - design/csr_irq_ctrl.sv
  - design/csr_read_decode.sv
  - design/csr_file.sv
  - target: test
    files:
      - dv/csr_tb.sv
